// File: tb.f
+incdir+common
common/mem_bus_pkg.sv
common/fetch_pkg.sv
fetch/fetch_request.sv
fetch/fetch_buffer.sv
hdl/fetch_pc_tracker.sv
hdl/fetch_unit.sv
verif/fetch_mem_model.sv
verif/fetch_unit_tb.sv

// File: Bender.yml
package:
  name: fetch_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mem_bus_pkg.sv
      - common/fetch_pkg.sv
      - fetch/fetch_request.sv
      - fetch/fetch_buffer.sv
      - hdl/fetch_pc_tracker.sv
      - hdl/fetch_unit.sv

  - target: test
    include_dirs:
      - common
    files:
      - verif/fetch_mem_model.sv
      - verif/fetch_unit_tb.sv

// File: verif/fetch_unit_tb.sv
`include "fetch_macros.svh"

module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_HW   = 256;
    localparam int NUM_ROWS = 6;
    localparam mem_bus_pkg::addr_t NO_FAULT = 32'hffff_fffc;

    // One test case
    typedef struct packed {
        mem_bus_pkg::addr_t start;
        logic [31:0]        ratio;         // Chance of a 32-bit instruction
        logic [7:0]         latency;
        logic [31:0]        stall_mask;    // Stall when all masked bits set
        mem_bus_pkg::addr_t fault;
        logic [15:0]        flush_cycle;   // Zero for no mid-stream flush
        mem_bus_pkg::addr_t flush_target;
        logic [15:0]        count;
    } row_t;

    logic                    g_clk;
    logic                    rst_n;
    logic                    flush;
    mem_bus_pkg::addr_t      flush_target;
    mem_bus_pkg::mem_req_t   mem_req;
    mem_bus_pkg::mem_rsp_t   mem_rsp;
    fetch_pkg::fetch_instr_t instr;
    logic                    instr_valid;
    logic                    instr_ready;
    logic [7:0]              latency;
    mem_bus_pkg::addr_t      fault_addr;
    logic                    mem_busy;

    row_t   rows [NUM_ROWS];
    integer seed;
    int     errors;
    int     checks;
    int     cycles;
    int     limit;

    fetch_unit UUT (
        .g_clk        (g_clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .flush_target (flush_target),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready)
    );

    fetch_mem_model #(.MEM_HW(MEM_HW)) mem_model (
        .g_clk      (g_clk),
        .rst_n      (rst_n),
        .latency    (latency),
        .fault_addr (fault_addr),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .busy       (mem_busy)
    );

    always #20 g_clk = ~g_clk;

    function automatic int half_index(input mem_bus_pkg::addr_t a);
        return int'((a >> 1) % MEM_HW);
    endfunction

    function automatic logic same_word(input mem_bus_pkg::addr_t a, input mem_bus_pkg::addr_t b);
        return a[31:2] == b[31:2];
    endfunction

    // Expected instruction at pc as decoded from the length bits
    function automatic fetch_pkg::fetch_instr_t expect_at(input mem_bus_pkg::addr_t pc,
                                                          input mem_bus_pkg::addr_t fault);
        fetch_pkg::fetch_instr_t e;
        fetch_pkg::half_t        lo;
        fetch_pkg::half_t        hi;
        lo      = mem_model.mem[half_index(pc)];
        hi      = mem_model.mem[half_index(pc + 32'd2)];
        e.pc    = pc;
        e.is_32 = lo[1:0] == 2'b11;
        e.instr = e.is_32 ? {hi, lo} : {16'h0000, lo};
        e.err   = same_word(pc, fault) || (e.is_32 && same_word(pc + 32'd2, fault));
        return e;
    endfunction

    task automatic check_instr(input fetch_pkg::fetch_instr_t got,
                               input fetch_pkg::fetch_instr_t exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pc(input mem_bus_pkg::addr_t got, input mem_bus_pkg::addr_t exp,
                            input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Force the length bits along one instruction walk
    task automatic shape_stream(input mem_bus_pkg::addr_t start, input int count,
                                input logic [31:0] ratio, input mem_bus_pkg::addr_t fault);
        mem_bus_pkg::addr_t pc;
        mem_bus_pkg::addr_t fw;
        logic [31:0]        rnd;
        logic               is32;
        logic [1:0]         lo;
        int                 idx;
        pc = start;
        fw = fault & ~32'd3;
        for (int n = 0; n < count + 4; n++) begin
            rnd  = $random(seed);
            is32 = rnd < ratio || ratio == 32'hffff_ffff;
            if (pc == fw - 32'd2 || pc == fw + 32'd2) begin
                is32 = 1'b1;          // Straddles into or out of the fault word
            end else if (pc == fw) begin
                is32 = 1'b0;
            end
            lo  = is32 ? 2'b11 : 2'(rnd[15:8] % 3);
            idx = half_index(pc);
            mem_model.mem[idx] = {mem_model.mem[idx][15:2], lo};
            pc = pc + (is32 ? 32'd4 : 32'd2);
        end
    endtask

    task automatic run_row(input int r);
        row_t                    row;
        int                      cyc;
        int                      got;
        int                      err_base;
        mem_bus_pkg::addr_t      exp_pc;
        mem_bus_pkg::addr_t      exp_req;
        mem_bus_pkg::addr_t      tgt;
        fetch_pkg::fetch_instr_t exp;
        fetch_pkg::fetch_instr_t held_instr;
        logic                    held;
        logic                    do_flush;
        logic                    flushed;
        logic                    stall;
        logic [31:0]             rnd;
        row      = rows[r];
        err_base = errors;
        @(negedge g_clk);
        rst_n       = 1'b0;
        flush       = 1'b0;
        instr_ready = 1'b0;
        latency     = row.latency;
        fault_addr  = row.fault;
        for (int i = 0; i < MEM_HW; i++) begin
            mem_model.mem[i] = 16'($random(seed));
        end
        shape_stream(row.start, row.count, row.ratio, row.fault);
        if (row.flush_cycle != 0) begin
            shape_stream(row.flush_target, row.count, row.ratio, row.fault);
        end
        repeat (4) @(negedge g_clk);
        rst_n   = 1'b1;
        exp_pc  = '0;                       // Reset address
        exp_req = '0;
        cyc     = 0;
        got     = 0;
        held    = 1'b0;
        flushed = 1'b0;
        while (got < row.count) begin
            @(negedge g_clk);
            // Outputs here come from registered state only
            if (held) begin
                checks++;
                if (!instr_valid) begin
                    errors++;
                    $display("instr_valid dropped at %0t while decode was stalling", $time);
                end else begin
                    check_instr(instr, held_instr, "instr while stalled");
                end
            end
            // Word reads walk the current stream one at a time
            if (mem_req.strobe) begin
                checks++;
                if (mem_busy || mem_rsp.strobe) begin
                    errors++;
                    $display("memory request at %0t while another was still outstanding",
                             $time);
                end
                check_pc(mem_req.addr, exp_req, "mem_req.addr");
                exp_req = exp_req + 32'd4;
            end
            do_flush = 1'b0;
            tgt      = '0;
            if (cyc == 0 && row.start != '0) begin
                do_flush = 1'b1;            // Start away from the reset address
                tgt      = row.start;
            end else if (!flushed && row.flush_cycle != 0 && cyc >= row.flush_cycle &&
                         (mem_req.strobe || mem_busy || mem_rsp.strobe)) begin
                do_flush = 1'b1;
                flushed  = 1'b1;
                tgt      = row.flush_target;
            end
            rnd          = $random(seed);
            stall        = row.stall_mask != 0 && (rnd & row.stall_mask) == row.stall_mask;
            flush        = do_flush;
            flush_target = tgt;
            instr_ready  = !do_flush && !stall;
            held         = 1'b0;
            if (do_flush) begin
                exp_pc  = tgt;
                exp_req = tgt & ~32'd3;
            end else if (instr_valid && instr_ready) begin
                exp = expect_at(exp_pc, row.fault);
                check_instr(instr, exp, "instr");
                check_pc(instr.pc, exp_pc, "instr.pc");
                exp_pc = exp_pc + (exp.is_32 ? 32'd4 : 32'd2);
                got++;
            end else if (instr_valid) begin
                held       = 1'b1;
                held_instr = instr;
            end
            cyc++;
            cycles++;
            if (cycles > limit) begin
                $display("timeout in row %0d: instructions stopped arriving", r);
                $display("Errors found");
                $finish;
            end
        end
        @(negedge g_clk);
        flush       = 1'b0;
        instr_ready = 1'b0;
        if (row.flush_cycle != 0 && !flushed) begin
            errors++;
            $display("row %0d ended before its flush could be applied", r);
        end
        $display("row %0d: %0d instructions, %0d failures", r, got, errors - err_base);
    endtask

    initial begin
        g_clk        = 1'b0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        flush_target = '0;
        instr_ready  = 1'b0;
        latency      = 8'd1;
        fault_addr   = NO_FAULT;
        seed         = 32'h78ca_b2da;
        errors       = 0;
        checks       = 0;
        cycles       = 0;

        // start, ratio, latency, stall mask, fault, flush cycle, flush target, count
        rows[0] = '{32'h0,  32'hffff_ffff, 8'd1, 32'h0, NO_FAULT, 16'd0,  32'h0,  16'd24};
        rows[1] = '{32'h0,  32'h8000_0000, 8'd2, 32'h0, NO_FAULT, 16'd0,  32'h0,  16'd40};
        rows[2] = '{32'h22, 32'h6000_0000, 8'd1, 32'h0, NO_FAULT, 16'd0,  32'h0,  16'd20};
        rows[3] = '{32'h40, 32'h8000_0000, 8'd4, 32'h3, NO_FAULT, 16'd0,  32'h0,  16'd40};
        rows[4] = '{32'h0,  32'h8000_0000, 8'd3, 32'h0, NO_FAULT, 16'd12, 32'h86, 16'd30};
        rows[5] = '{32'h10, 32'ha000_0000, 8'd2, 32'h0, 32'h18,   16'd0,  32'h0,  16'd20};

        limit = 50;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += int'(rows[r].count) * (int'(rows[r].latency) + 3);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("rows %0d, checks %0d, failures %0d", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verif/fetch_mem_model.sv
`include "fetch_macros.svh"

module fetch_mem_model #(
    parameter int MEM_HW = 256
) (
    input  logic                  g_clk,
    input  logic                  rst_n,
    input  logic [7:0]            latency,     // Cycles from request to response
    input  mem_bus_pkg::addr_t    fault_addr,  // Word answering with err
    input  mem_bus_pkg::mem_req_t mem_req,
    output mem_bus_pkg::mem_rsp_t mem_rsp,
    output logic                  busy
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`FETCH_HW-1:0] mem [MEM_HW];  // Program halfwords, written by the testbench
    mem_bus_pkg::addr_t   addr_q;
    logic [7:0]           cnt;

    function automatic mem_bus_pkg::mem_rsp_t read_word(input mem_bus_pkg::addr_t addr);
        mem_bus_pkg::mem_rsp_t rsp;
        int                    idx;
        idx        = int'((addr >> 1) % MEM_HW);
        rsp.strobe = 1'b1;
        rsp.data   = {mem[(idx + 1) % MEM_HW], mem[idx]};
        rsp.err    = addr[31:2] == fault_addr[31:2];
        return rsp;
    endfunction

    // One request at a time, answered after the programmed latency
    always @(posedge g_clk) begin
        if (!rst_n) begin
            mem_rsp <= '0;
            busy    <= 1'b0;
            cnt     <= '0;
            addr_q  <= '0;
        end else begin
            mem_rsp.strobe <= 1'b0;
            if (mem_req.strobe && latency <= 8'd1) begin
                mem_rsp <= read_word(mem_req.addr);  // Next cycle answer
            end else if (mem_req.strobe) begin
                addr_q <= mem_req.addr;
                cnt    <= latency - 8'd1;
                busy   <= 1'b1;
            end else if (busy) begin
                if (cnt == 8'd1) begin
                    mem_rsp <= read_word(addr_q);
                    busy    <= 1'b0;
                end
                cnt <= cnt - 8'd1;
            end
        end
    end

endmodule

// File: hdl/fetch_unit.sv
module fetch_unit (
    input  logic                    g_clk,
    input  logic                    rst_n,
    input  logic                    flush,          // One-cycle pulse
    input  mem_bus_pkg::addr_t      flush_target,
    output mem_bus_pkg::mem_req_t   mem_req,
    input  mem_bus_pkg::mem_rsp_t   mem_rsp,
    output fetch_pkg::fetch_instr_t instr,
    output logic                    instr_valid,
    input  logic                    instr_ready     // Decode accepts the head
);

    logic               load_4;
    logic               load_2;
    logic               load_err;
    mem_bus_pkg::word_t load_word;
    fetch_pkg::depth_t  buf_depth;   // Feeds the request credit rule
    mem_bus_pkg::word_t buf_out;
    logic               buf_32;
    logic               buf_err;

    fetch_request u_request (
        .g_clk        (g_clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .flush_target (flush_target),
        .buf_depth    (buf_depth),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .load_4       (load_4),
        .load_2       (load_2),
        .load_err     (load_err),
        .load_word    (load_word)
    );

    fetch_buffer u_buffer (
        .g_clk     (g_clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .load_4    (load_4),
        .load_2    (load_2),
        .load_err  (load_err),
        .load_word (load_word),
        .buf_depth (buf_depth),
        .buf_out   (buf_out),
        .buf_32    (buf_32),
        .buf_err   (buf_err),
        .buf_valid (instr_valid),
        .buf_ready (instr_ready)
    );

    fetch_pc_tracker u_pc_tracker (
        .g_clk        (g_clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .flush_target (flush_target),
        .buf_out      (buf_out),
        .buf_32       (buf_32),
        .buf_err      (buf_err),
        .buf_valid    (instr_valid),
        .buf_ready    (instr_ready),
        .instr        (instr)
    );

endmodule

// File: hdl/fetch_pc_tracker.sv
`include "fetch_macros.svh"

module fetch_pc_tracker (
    input  logic                    g_clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  mem_bus_pkg::addr_t      flush_target,
    input  mem_bus_pkg::word_t      buf_out,
    input  logic                    buf_32,
    input  logic                    buf_err,
    input  logic                    buf_valid,
    input  logic                    buf_ready,
    output fetch_pkg::fetch_instr_t instr
);

    mem_bus_pkg::addr_t pc;       // Address of the instruction at the buffer head
    mem_bus_pkg::addr_t step;

    assign step = buf_32 ? mem_bus_pkg::addr_t'(4) : mem_bus_pkg::addr_t'(2);

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (flush) begin
            pc <= flush_target;           // Keeps bit 1 for odd-halfword starts
        end else if (buf_valid && buf_ready) begin
            pc <= pc + step;
        end
    end

    always_comb begin
        instr.pc    = pc;
        instr.is_32 = buf_32;
        instr.err   = buf_err;
        if (buf_32) begin
            instr.instr = buf_out;
        end else begin
            // Compressed parcel only
            instr.instr = {{`FETCH_HW{1'b0}}, buf_out[`FETCH_HW-1:0]};
        end
    end

endmodule

// File: fetch/fetch_buffer.sv
`include "fetch_macros.svh"

module fetch_buffer (
    input  logic                 g_clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 load_4,     // Whole word arrives
    input  logic                 load_2,     // Upper halfword only
    input  logic                 load_err,
    input  mem_bus_pkg::word_t   load_word,
    output fetch_pkg::depth_t    buf_depth,
    output mem_bus_pkg::word_t   buf_out,
    output logic                 buf_32,
    output logic                 buf_err,
    output logic                 buf_valid,
    input  logic                 buf_ready
);

    fetch_pkg::hw_entry_t buffer   [`FETCH_BUF_HW];
    fetch_pkg::hw_entry_t n_buffer [`FETCH_BUF_HW];
    fetch_pkg::depth_t    depth;
    fetch_pkg::depth_t    n_depth;
    fetch_pkg::hw_entry_t lo_in;
    fetch_pkg::hw_entry_t hi_in;
    logic                 eat_2;
    logic                 eat_4;

    assign lo_in = '{err: load_err, data: load_word[`FETCH_HW-1:0]};
    assign hi_in = '{err: load_err, data: load_word[2*`FETCH_HW-1:`FETCH_HW]};

    // Head of the buffer is always entry 0
    assign buf_out   = {buffer[1].data, buffer[0].data};
    assign buf_32    = buffer[0].data[1:0] == 2'b11;
    assign buf_depth = depth;

    // Enough parcels present for the instruction at the head
    assign buf_valid = depth >= fetch_pkg::depth_t'(2) ||
                       (depth == fetch_pkg::depth_t'(1) && !buf_32);

    // Fault covers every parcel the instruction touches
    assign buf_err = buffer[0].err || (buf_32 && buffer[1].err);

    assign eat_2 = buf_valid && buf_ready && !buf_32;
    assign eat_4 = buf_valid && buf_ready &&  buf_32;

    always_comb begin
        fetch_pkg::depth_t kept;

        n_buffer = buffer;
        kept     = depth;

        // Drop consumed parcels and move the rest to the head
        if (eat_4) begin
            n_buffer[0] = buffer[2];
            kept        = depth - fetch_pkg::depth_t'(2);
        end else if (eat_2) begin
            n_buffer[0] = buffer[1];
            n_buffer[1] = buffer[2];
            kept        = depth - fetch_pkg::depth_t'(1);
        end

        n_depth = kept;

        // Append behind whatever is left
        // Requests are only issued at depth 0 or 1, so the word fits
        if (load_4) begin
            case (kept)
                fetch_pkg::depth_t'(0): begin
                    n_buffer[0] = lo_in;
                    n_buffer[1] = hi_in;
                end
                fetch_pkg::depth_t'(1): begin
                    n_buffer[1] = lo_in;
                    n_buffer[2] = hi_in;
                end
                default: begin
                    n_buffer[2] = lo_in;
                end
            endcase
            n_depth = kept + fetch_pkg::depth_t'(2);
        end else if (load_2) begin
            case (kept)
                fetch_pkg::depth_t'(0): n_buffer[0] = hi_in;  // Odd-halfword target
                fetch_pkg::depth_t'(1): n_buffer[1] = hi_in;
                default:                n_buffer[2] = hi_in;
            endcase
            n_depth = kept + fetch_pkg::depth_t'(1);
        end
    end

    always_ff @(posedge g_clk) begin
        if (!rst_n || flush) begin
            depth <= '0;
        end else begin
            depth <= n_depth;
        end
    end

    // Parcel storage
    always_ff @(posedge g_clk) begin
        buffer <= n_buffer;
    end

endmodule

// File: fetch/fetch_request.sv
module fetch_request (
    input  logic                  g_clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  mem_bus_pkg::addr_t    flush_target,
    input  fetch_pkg::depth_t     buf_depth,
    output mem_bus_pkg::mem_req_t mem_req,
    input  mem_bus_pkg::mem_rsp_t mem_rsp,
    output logic                  load_4,
    output logic                  load_2,
    output logic                  load_err,
    output mem_bus_pkg::word_t    load_word
);

    fetch_pkg::req_state_t state;
    fetch_pkg::req_state_t n_state;
    mem_bus_pkg::addr_t    next_addr;   // Next word to read
    mem_bus_pkg::addr_t    target_word; // Flush target rounded down
    mem_bus_pkg::addr_t    issue_addr;
    logic                  first_half;  // Next live response fills upper half only
    logic                  rsp_live;
    logic                  issue;

    assign target_word = flush_target & ~mem_bus_pkg::addr_t'(3);

    // Only a response in WAIT belongs to the current stream
    assign rsp_live = mem_rsp.strobe && state == fetch_pkg::WAIT;

    assign load_4    = rsp_live && !flush && !first_half;
    assign load_2    = rsp_live && !flush &&  first_half;
    assign load_err  = mem_rsp.err;
    assign load_word = mem_rsp.data;

    // Credit rule allows one request in flight and only at low depth
    // so a returning word always fits
    always_comb begin
        n_state    = state;
        issue      = 1'b0;
        issue_addr = next_addr;
        case (state)
            fetch_pkg::IDLE: begin
                if (flush) begin
                    issue      = 1'b1;
                    issue_addr = target_word;
                end else if (buf_depth <= fetch_pkg::depth_t'(1)) begin
                    issue = 1'b1;
                end
            end
            fetch_pkg::WAIT: begin
                if (mem_rsp.strobe && flush) begin
                    issue      = 1'b1;           // Drop the response and restart at once
                    issue_addr = target_word;
                end else if (mem_rsp.strobe) begin
                    n_state = fetch_pkg::IDLE;   // Let depth settle first
                end else if (flush) begin
                    n_state = fetch_pkg::DISCARD;
                end
            end
            fetch_pkg::DISCARD: begin
                if (mem_rsp.strobe) begin
                    issue = 1'b1;                // Stale word gone so fetch the target
                    if (flush) begin
                        issue_addr = target_word;
                    end
                end
            end
            default: begin
                n_state = fetch_pkg::IDLE;
            end
        endcase
        if (issue) begin
            n_state = fetch_pkg::WAIT;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            state          <= fetch_pkg::IDLE;
            mem_req.strobe <= 1'b0;
            mem_req.addr   <= '0;
            next_addr      <= '0;             // Reset address
            first_half     <= 1'b0;
        end else begin
            state          <= n_state;
            mem_req.strobe <= issue;
            if (issue) begin
                mem_req.addr <= issue_addr;
                next_addr    <= issue_addr + mem_bus_pkg::addr_t'(4);
            end else if (flush) begin
                next_addr <= target_word;     // Held until the stale word returns
            end
            if (flush) begin
                first_half <= flush_target[1];
            end else if (rsp_live) begin
                first_half <= 1'b0;
            end
        end
    end

endmodule

// File: common/fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

    typedef logic [`FETCH_HW-1:0] half_t;

    // One buffered parcel with its fault flag
    typedef struct packed {
        logic  err;
        half_t data;
    } hw_entry_t;

    // Halfwords held in the buffer, 0 to FETCH_BUF_HW
    typedef logic [$clog2(`FETCH_BUF_HW + 1)-1:0] depth_t;

    // Instruction handed to decode
    typedef struct packed {
        logic [`FETCH_XLEN-1:0] instr;  // Upper half zero when 16-bit
        logic [`FETCH_XLEN-1:0] pc;
        logic                   is_32;
        logic                   err;
    } fetch_instr_t;

    // Memory request FSM
    typedef enum logic [1:0] {
        IDLE,     // Free to issue
        WAIT,     // Response pending
        DISCARD   // Response pending but stale after a flush
    } req_state_t;

endpackage

// File: common/mem_bus_pkg.sv
`include "fetch_macros.svh"

package mem_bus_pkg;

    // Byte address, requests keep bits 1:0 at zero
    typedef logic [`FETCH_XLEN-1:0] addr_t;

    // One instruction memory word
    typedef logic [`FETCH_XLEN-1:0] word_t;

    // Read request toward instruction memory
    typedef struct packed {
        logic  strobe;  // One-cycle request pulse
        addr_t addr;    // Word aligned
    } mem_req_t;

    // Read response, exactly one per request
    typedef struct packed {
        logic  strobe;  // One-cycle response pulse
        word_t data;
        logic  err;     // Bus fault on this word
    } mem_rsp_t;

endpackage

// File: common/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Memory word width in bits
`define FETCH_XLEN 32

// One compressed instruction parcel
`define FETCH_HW 16

// Realignment buffer capacity, in halfwords
`define FETCH_BUF_HW 3

`endif
